//--- source/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// board SRAM geometry, 256K words of 16 bits

// word address width
`define SRAM_ADDR_BITS 18

// data bus width
`define SRAM_DATA_BITS 16

// clocks that write enable stays low per write
// two clocks cover the write pulse width of a 10 ns part at the board clock
`define SRAM_WE_CYCLES 2

`endif

//--- source/sram_bus_pkg.sv
`default_nettype none

`include "sram_params.svh"

package sram_bus_pkg;

  // word address into the external array
  typedef logic [`SRAM_ADDR_BITS-1:0] sram_addr_t;

  // one data word as seen by the client
  typedef logic [`SRAM_DATA_BITS-1:0] sram_data_t;

  // request kind, single bit so the request struct stays 35 bits
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } sram_op_e;

  // client request, wdata ignored for reads
  typedef struct packed {
    sram_op_e   op;
    sram_addr_t addr;
    sram_data_t wdata;
  } sram_req_t;

  // read result, returned in request order
  typedef struct packed {
    sram_data_t rdata;
  } sram_resp_t;

endpackage

`default_nettype wire

//--- source/sram_pin_pkg.sv
`default_nettype none

package sram_pin_pkg;

  import sram_bus_pkg::*;

  // one cycle of pin activity before pad retiming
  // strobes are active low like the chip pins
  typedef struct packed {
    logic       ce_n;
    logic       we_n;
    logic       oe_n;
    sram_addr_t addr;
    sram_data_t wdata;
    logic       wdata_en;
  } sram_pad_cmd_t;

  // controller states
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_wr_setup  = 3'd1,
    st_wr_strobe = 3'd2,
    st_wr_hold   = 3'd3,
    st_read      = 3'd4
  } sram_ctrl_state_e;

endpackage

`default_nettype wire

//--- source/sram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_params.svh"

module sram_ctrl
  import sram_bus_pkg::*;
  import sram_pin_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          req_valid,
  input  sram_req_t     req,
  output logic          req_ready,
  output sram_pad_cmd_t cmd
);

  // strobe counter sized to hold 0 .. SRAM_WE_CYCLES
  localparam int unsigned strobe_bits = $clog2(`SRAM_WE_CYCLES + 1);
  localparam logic [strobe_bits-1:0] strobe_last = strobe_bits'(`SRAM_WE_CYCLES - 1);

  sram_ctrl_state_e       state;
  sram_ctrl_state_e       state_next;
  logic [strobe_bits-1:0] strobe_cnt;
  sram_req_t              req_q;
  logic                   accept;
  logic                   accept_rd;

  // ready in idle for anything
  // while reading only another read may follow, a write waits for idle
  // so the bus gets a turnaround cycle
  assign req_ready = (state == st_idle) || ((state == st_read) && (req.op == op_read));

  assign accept    = req_valid && req_ready;
  assign accept_rd = accept && (req.op == op_read);

  always_comb begin
    state_next = state;
    case (state)
      // writes are only accepted from idle, so an accept in st_read is a read
      st_idle, st_read: begin
        if (accept) begin
          state_next = (req.op == op_write) ? st_wr_setup : st_read;
        end else begin
          state_next = st_idle;
        end
      end
      st_wr_setup: begin
        state_next = st_wr_strobe;
      end
      st_wr_strobe: begin
        // leave after the last strobe clock
        if (strobe_cnt == strobe_last) begin
          state_next = st_wr_hold;
        end
      end
      st_wr_hold: begin
        state_next = st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      strobe_cnt <= '0;
    end else begin
      state <= state_next;
      // counts strobe clocks, cleared in every other state
      if (state == st_wr_strobe) begin
        strobe_cnt <= strobe_cnt + 1'b1;
      end else begin
        strobe_cnt <= '0;
      end
    end
  end

  // request payload, held for the whole write sequence or read cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

  always_comb begin
    // idle command, strobes high and bus released
    cmd.ce_n     = 1'b1;
    cmd.we_n     = 1'b1;
    cmd.oe_n     = 1'b1;
    cmd.addr     = req_q.addr;
    cmd.wdata    = req_q.wdata;
    cmd.wdata_en = 1'b0;
    case (state)
      st_wr_setup: begin
        // address and data settle before the strobe
        cmd.ce_n     = 1'b0;
        cmd.wdata_en = 1'b1;
      end
      st_wr_strobe: begin
        cmd.ce_n     = 1'b0;
        cmd.we_n     = 1'b0;
        cmd.wdata_en = 1'b1;
      end
      st_wr_hold: begin
        // we_n rises at the pin half a cycle later, data still driven
        cmd.ce_n     = 1'b0;
        cmd.wdata_en = 1'b1;
      end
      st_read: begin
        cmd.ce_n = 1'b0;
        cmd.oe_n = 1'b0;
      end
      default: begin
      end
    endcase
    // output enable goes out one cycle ahead of the read address
    // the pad delays oe by an extra half cycle, so the chip is already
    // driving when the falling edge samples the data
    if (accept_rd) begin
      cmd.oe_n = 1'b0;
    end
  end

  // never drive the bus while the chip may be driving it
  a_no_drive_during_oe: assert property (@(posedge clk) disable iff (reset)
    !(cmd.wdata_en && !cmd.oe_n));

  // bus turnaround, one cycle without drive after output enable
  a_turnaround: assert property (@(posedge clk) disable iff (reset)
    !cmd.oe_n |=> !cmd.wdata_en);

  // each write pulse lasts exactly SRAM_WE_CYCLES clocks
  a_strobe_len: assert property (@(posedge clk) disable iff (reset)
    $fell(cmd.we_n) |-> (!cmd.we_n) [*`SRAM_WE_CYCLES] ##1 cmd.we_n);

endmodule

`default_nettype wire

//--- source/sram_io.sv
`timescale 1ns/1ns
`default_nettype none

module sram_io
  import sram_bus_pkg::*;
  import sram_pin_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  sram_pad_cmd_t cmd,
  input  sram_data_t    io_data_in,
  output sram_data_t    rdata,
  output logic          rdata_valid,
  output logic          io_ce_n,
  output logic          io_we_n,
  output logic          io_oe_n,
  output sram_addr_t    io_addr,
  output sram_data_t    io_data_out,
  output logic          io_data_oe
);

  // rising edge output registers
  logic       ce_n_q;
  logic       we_n_q;
  logic       oe_n_q;
  logic       data_oe_q;
  sram_addr_t addr_q;
  sram_data_t wdata_q;

  // falling edge retimed strobes
  logic       we_n_f;
  logic       oe_n_f;

  // read capture
  sram_data_t rdata_f;
  logic       rd_act;

  always_ff @(posedge clk) begin
    if (reset) begin
      ce_n_q    <= 1'b1;
      we_n_q    <= 1'b1;
      oe_n_q    <= 1'b1;
      data_oe_q <= 1'b0;
    end else begin
      ce_n_q    <= cmd.ce_n;
      we_n_q    <= cmd.we_n;
      oe_n_q    <= cmd.oe_n;
      data_oe_q <= cmd.wdata_en;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= cmd.addr;
    wdata_q <= cmd.wdata;
  end

  // half cycle later, keeps the write pulse inside the address window
  always_ff @(negedge clk) begin
    if (reset) begin
      we_n_f <= 1'b1;
      oe_n_f <= 1'b1;
    end else begin
      we_n_f <= we_n_q;
      oe_n_f <= oe_n_q;
    end
  end

  // a read cycle is under way at the pins
  assign rd_act = !ce_n_q && !oe_n_q;

  // sample in the middle of the address window
  always_ff @(negedge clk) begin
    if (rd_act) begin
      rdata_f <= io_data_in;
    end
  end

  // move the sample back into the rising edge domain
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= rd_act;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_act) begin
      rdata <= rdata_f;
    end
  end

  assign io_ce_n     = ce_n_q;
  assign io_we_n     = we_n_f;
  assign io_oe_n     = oe_n_f;
  assign io_addr     = addr_q;
  assign io_data_out = wdata_q;
  assign io_data_oe  = data_oe_q;

  // pins move on both edges, so check contention on both
  a_no_contention_rise: assert property (@(posedge clk) disable iff (reset)
    !(io_data_oe && !io_oe_n));

  a_no_contention_fall: assert property (@(negedge clk) disable iff (reset)
    !(io_data_oe && !io_oe_n));

endmodule

`default_nettype wire

//--- source/sram_top.sv
`timescale 1ns/1ns
`default_nettype none

module sram_top
  import sram_bus_pkg::*;
  import sram_pin_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_valid,
  input  sram_req_t  req,
  output logic       req_ready,
  output logic       resp_valid,
  output sram_resp_t resp,
  output logic       io_ce_n,
  output logic       io_we_n,
  output logic       io_oe_n,
  output sram_addr_t io_addr,
  output sram_data_t io_data_out,
  output logic       io_data_oe,
  input  sram_data_t io_data_in
);

  // pin command from the FSM to the pad stage
  sram_pad_cmd_t cmd;

  // read return path
  sram_data_t    rdata;
  logic          rdata_valid;

  sram_ctrl sram_ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_valid(req_valid),
    .req      (req),
    .req_ready(req_ready),
    .cmd      (cmd)
  );

  sram_io sram_io_i (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .io_data_in (io_data_in),
    .rdata      (rdata),
    .rdata_valid(rdata_valid),
    .io_ce_n    (io_ce_n),
    .io_we_n    (io_we_n),
    .io_oe_n    (io_oe_n),
    .io_addr    (io_addr),
    .io_data_out(io_data_out),
    .io_data_oe (io_data_oe)
  );

  // responses have no back-pressure, the client always accepts
  assign resp_valid = rdata_valid;
  assign resp.rdata = rdata;

endmodule

`default_nettype wire

//--- verification/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_params.svh"

// behavioral asynchronous SRAM on the split data bus
module sram_model
  import sram_bus_pkg::*;
(
  input  logic       ce_n,
  input  logic       we_n,
  input  logic       oe_n,
  input  sram_addr_t addr,
  input  sram_data_t ctrl_data,
  input  logic       ctrl_data_oe,
  output sram_data_t chip_data
);

  localparam int unsigned depth = 1 << `SRAM_ADDR_BITS;

  sram_data_t mem [depth];

  // power-up contents, every address bit folds into the word
  initial begin
    logic [31:0] a;
    for (int i = 0; i < depth; i++) begin
      a      = i;
      mem[i] = sram_data_t'(a ^ (a >> 7) ^ 32'h3c5a);
    end
  end

  // chip drives the bus while selected with output enable low
  assign chip_data = (!ce_n && !oe_n) ? mem[addr] : '0;

  // write lands when the write pulse ends
  always @(posedge we_n) begin
    if (!ce_n && ctrl_data_oe) begin
      mem[addr] <= ctrl_data;
    end
  end

endmodule

`default_nettype wire

//--- verification/sram_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_params.svh"

module sram_top_tb
  import sram_bus_pkg::*;
();

  // loop limits in clocks
  localparam int accept_limit = 32;
  localparam int drain_limit  = 64;
  // setup, strobe clocks and hold of one write
  localparam int write_busy   = `SRAM_WE_CYCLES + 2;

  logic       clk = 1'b0;
  logic       reset;
  logic       req_valid;
  sram_req_t  req;
  logic       req_ready;
  logic       resp_valid;
  sram_resp_t resp;
  logic       io_ce_n;
  logic       io_we_n;
  logic       io_oe_n;
  sram_addr_t io_addr;
  sram_data_t io_data_out;
  logic       io_data_oe;
  sram_data_t io_data_in;

  integer     seed = 32'h590d;
  string      test_name;
  logic       reset_check;
  logic [5:0] idle_pins;

  // reference memory and read results still owed by the DUT
  sram_data_t ref_mem [sram_addr_t];
  sram_data_t exp_q [$];
  sram_addr_t written [$];
  logic       accepted;
  int         wr_busy;

  // one captured response that is checked half a clock later
  logic       chk_valid;
  logic       chk_extra;
  sram_data_t chk_exp;
  sram_data_t chk_act;
  string      chk_test;

  sram_top sram_top_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .io_ce_n    (io_ce_n),
    .io_we_n    (io_we_n),
    .io_oe_n    (io_oe_n),
    .io_addr    (io_addr),
    .io_data_out(io_data_out),
    .io_data_oe (io_data_oe),
    .io_data_in (io_data_in)
  );

  sram_model sram_model_i (
    .ce_n        (io_ce_n),
    .we_n        (io_we_n),
    .oe_n        (io_oe_n),
    .addr        (io_addr),
    .ctrl_data   (io_data_out),
    .ctrl_data_oe(io_data_oe),
    .chip_data   (io_data_in)
  );

  always #2 clk = ~clk;

  // strobes high, bus released, no response, ready
  assign idle_pins = {io_ce_n, io_we_n, io_oe_n, io_data_oe, resp_valid, req_ready};

  always @(posedge clk) begin
    if (reset) begin
      accepted  <= 1'b0;
      wr_busy   <= 0;
      chk_valid <= 1'b0;
    end else begin
      accepted  <= req_valid && req_ready;
      chk_valid <= resp_valid;
      // a read accepted on this edge cannot answer on it, so pop first
      if (resp_valid) begin
        chk_act   <= resp.rdata;
        chk_test  <= test_name;
        chk_extra <= (exp_q.size() == 0);
        if (exp_q.size() != 0) begin
          chk_exp <= exp_q.pop_front();
        end
      end
      if (req_valid && req_ready && req.op == op_write) begin
        ref_mem[req.addr] = req.wdata;
        wr_busy <= write_busy;
      end else begin
        if (req_valid && req_ready) begin
          exp_q.push_back(ref_mem[req.addr]);
        end
        if (wr_busy != 0) begin
          wr_busy <= wr_busy - 1;
        end
      end
    end
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  a_reset_idle: assert property (@(posedge clk) disable iff (reset)
    reset_check |-> idle_pins == 6'b111001)
    else stop_run($sformatf("mismatch test=%s expected=%b actual=%b",
                            test_name, 6'b111001, idle_pins));

  a_resp_owed: assert property (@(negedge clk) disable iff (reset)
    chk_valid |-> !chk_extra)
    else stop_run($sformatf("%s: response arrived with no read outstanding", chk_test));

  a_resp_data: assert property (@(negedge clk) disable iff (reset)
    chk_valid && !chk_extra |-> chk_act == chk_exp)
    else stop_run($sformatf("mismatch test=%s expected=%h actual=%h",
                            chk_test, chk_exp, chk_act));

  // pins move on both edges
  a_bus_free_rise: assert property (@(posedge clk) disable iff (reset)
    !(io_data_oe && !io_oe_n))
    else stop_run("controller drives the data bus while the SRAM output is on");

  a_bus_free_fall: assert property (@(negedge clk) disable iff (reset)
    !(io_data_oe && !io_oe_n))
    else stop_run("controller drives the data bus while the SRAM output is on");

  a_ready_low_in_write: assert property (@(posedge clk) disable iff (reset)
    wr_busy != 0 |-> !req_ready)
    else stop_run($sformatf("%s: req_ready high during a write", test_name));

  function automatic sram_addr_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[`SRAM_ADDR_BITS-1:0];
  endfunction

  function automatic sram_data_t rand_data();
    logic [31:0] r;
    r = $random(seed);
    return r[`SRAM_DATA_BITS-1:0];
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % unsigned'(n));
  endfunction

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic send_req(input sram_op_e op, input sram_addr_t addr, input sram_data_t wdata);
    int waited;
    waited    = 0;
    req_valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    do begin
      @(negedge clk);
      waited++;
      if (waited > accept_limit) begin
        stop_run($sformatf("%s: request not accepted within %0d clocks",
                           test_name, accept_limit));
      end
    end while (!accepted);
  endtask

  task automatic write_word(input sram_addr_t addr, input sram_data_t data);
    send_req(op_write, addr, data);
    written.push_back(addr);
  endtask

  task automatic read_word(input sram_addr_t addr);
    send_req(op_read, addr, '0);
  endtask

  task automatic hold_idle(input int cycles);
    req_valid = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  // waits until every accepted read has answered
  task automatic wait_drain();
    int waited;
    waited    = 0;
    req_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > drain_limit) begin
        stop_run($sformatf("%s: %0d read responses never arrived", test_name, exp_q.size()));
      end
    end
    @(negedge clk);
  endtask

  initial begin
    sram_addr_t addr;
    sram_data_t data;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    reset_check = 1'b0;
    test_name   = "reset";
    repeat (3) @(negedge clk);
    reset       = 1'b0;
    reset_check = 1'b1;
    hold_idle(2);
    reset_check = 1'b0;

    test_name = "write_read";
    addr = rand_addr();
    data = rand_data();
    write_word(addr, data);
    read_word(addr);
    wait_drain();

    // inverted word so the later value differs in every bit
    test_name = "overwrite";
    write_word(addr, ~data);
    read_word(addr);
    wait_drain();

    test_name = "read_burst";
    repeat (16) write_word(rand_addr(), rand_data());
    // valid stays high from read to read
    repeat (24) read_word(written[rand_below(written.size())]);
    wait_drain();

    test_name = "random_mix";
    repeat (300) begin
      if (rand_below(2) == 0) begin
        // some writes hit a known address again
        if (rand_below(4) == 0) begin
          write_word(written[rand_below(written.size())], rand_data());
        end else begin
          write_word(rand_addr(), rand_data());
        end
      end else begin
        read_word(written[rand_below(written.size())]);
      end
      if (rand_below(2) == 0) begin
        hold_idle(rand_below(4));
      end
    end
    // every owed read must answer, and no extra response may follow
    wait_drain();
    hold_idle(4);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/sram_bus_pkg.sv
source/sram_pin_pkg.sv
source/sram_ctrl.sv
source/sram_io.sv
source/sram_top.sv
verification/sram_model.sv
verification/sram_top_tb.sv

//--- run.sh
#!/bin/sh
# build and run the SRAM controller testbench with Verilator
# exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module sram_top_tb -Mdir obj_dir -o sram_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sram_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi

exit 0
